//--- design/core_pkg.sv
package core_pkg;

    localparam int DATA_WIDTH    = 32;
    localparam int INSTR_WIDTH   = 32;
    localparam int GPR_NUM       = 32;
    localparam int ALU_OP_WIDTH  = 8;
    localparam int ALU_SEL_WIDTH = 3;

    typedef logic [DATA_WIDTH-1:0]      data_t;
    typedef logic [INSTR_WIDTH-1:0]     instr_t;
    typedef logic [$clog2(GPR_NUM)-1:0] reg_addr_t;
    typedef logic [ALU_OP_WIDTH-1:0]    aluop_t;
    typedef logic [ALU_SEL_WIDTH-1:0]   alusel_t;
    typedef logic [1:0]                 mem_size_t;

    // Access sizes
    localparam mem_size_t MEM_SIZE_B = 2'd0;
    localparam mem_size_t MEM_SIZE_H = 2'd1;
    localparam mem_size_t MEM_SIZE_W = 2'd2;

    // 2RI12 major opcodes, instr[31:22]
    localparam logic [9:0] EXE_SLTI   = 10'h008;
    localparam logic [9:0] EXE_SLTUI  = 10'h009;
    localparam logic [9:0] EXE_ADDI_W = 10'h00a;
    localparam logic [9:0] EXE_ANDI   = 10'h00d;
    localparam logic [9:0] EXE_ORI    = 10'h00e;
    localparam logic [9:0] EXE_XORI   = 10'h00f;
    localparam logic [9:0] EXE_CACOP  = 10'h018;
    localparam logic [9:0] EXE_LD_B   = 10'h0a0;
    localparam logic [9:0] EXE_LD_H   = 10'h0a1;
    localparam logic [9:0] EXE_LD_W   = 10'h0a2;
    localparam logic [9:0] EXE_ST_B   = 10'h0a4;
    localparam logic [9:0] EXE_ST_H   = 10'h0a5;
    localparam logic [9:0] EXE_ST_W   = 10'h0a6;
    localparam logic [9:0] EXE_LD_BU  = 10'h0a8;
    localparam logic [9:0] EXE_LD_HU  = 10'h0a9;
    localparam logic [9:0] EXE_PRELD  = 10'h0ab;

    // 1RI20 opcodes, instr[31:25]
    localparam logic [6:0] EXE_LU12I_W   = 7'h0a;
    localparam logic [6:0] EXE_PCADDU12I = 7'h0e;

    // ALU operation codes
    localparam aluop_t EXE_NOP_OP    = 8'h00;
    localparam aluop_t EXE_SLT_OP    = 8'h01;
    localparam aluop_t EXE_SLTU_OP   = 8'h02;
    localparam aluop_t EXE_ADD_OP    = 8'h03;
    localparam aluop_t EXE_AND_OP    = 8'h04;
    localparam aluop_t EXE_OR_OP     = 8'h05;
    localparam aluop_t EXE_XOR_OP    = 8'h06;
    localparam aluop_t EXE_LD_B_OP   = 8'h08;
    localparam aluop_t EXE_LD_H_OP   = 8'h09;
    localparam aluop_t EXE_LD_W_OP   = 8'h0a;
    localparam aluop_t EXE_ST_B_OP   = 8'h0b;
    localparam aluop_t EXE_ST_H_OP   = 8'h0c;
    localparam aluop_t EXE_ST_W_OP   = 8'h0d;
    localparam aluop_t EXE_LD_BU_OP  = 8'h0e;
    localparam aluop_t EXE_LD_HU_OP  = 8'h0f;
    localparam aluop_t EXE_CACOP_OP  = 8'h10;
    localparam aluop_t EXE_LUI_OP    = 8'h11;
    localparam aluop_t EXE_PCADDU_OP = 8'h12;

    // Result selectors
    localparam alusel_t EXE_RES_NOP        = 3'd0;
    localparam alusel_t EXE_RES_LOGIC      = 3'd1;
    localparam alusel_t EXE_RES_ARITH      = 3'd2;
    localparam alusel_t EXE_RES_LOAD_STORE = 3'd3;

endpackage

//--- design/decoder_2ri12.sv
`timescale 1ns/10ps

// Format {opcode[10], imm12, rj, rd}
module decoder_2ri12 (
    input  core_pkg::instr_t    instr_i,
    output logic                decode_valid_o,
    output logic [1:0]          reg_read_valid_o, // {rk/rd, rj}
    output core_pkg::reg_addr_t rj_addr_o,
    output core_pkg::reg_addr_t rk_addr_o,
    output logic                use_imm_o,
    output core_pkg::data_t     imm_o,
    output logic                wb_en_o,
    output core_pkg::reg_addr_t wb_addr_o,
    output core_pkg::aluop_t    aluop_o,
    output core_pkg::alusel_t   alusel_o,
    output logic                mem_load_o,
    output logic                mem_store_o,
    output core_pkg::mem_size_t mem_size_o,
    output logic                kernel_o,
    output logic                refetch_o
);

    logic [9:0]          opcode;
    logic [11:0]         imm12;
    core_pkg::reg_addr_t rd;
    core_pkg::reg_addr_t rj;
    core_pkg::data_t     imm_sext;
    core_pkg::data_t     imm_zext;

    assign opcode   = instr_i[31:22];
    assign imm12    = instr_i[21:10];
    assign rj       = instr_i[9:5];
    assign rd       = instr_i[4:0];
    assign imm_sext = {{20{imm12[11]}}, imm12};
    assign imm_zext = {20'b0, imm12};

    always_comb begin
        // Immediate ALU op by default, reads rj and writes rd
        decode_valid_o   = 1'b1;
        reg_read_valid_o = 2'b01;
        rj_addr_o        = rj;
        rk_addr_o        = '0;
        use_imm_o        = 1'b1;
        imm_o            = imm_sext;
        wb_en_o          = 1'b1;
        wb_addr_o        = rd;
        aluop_o          = core_pkg::EXE_NOP_OP;
        alusel_o         = core_pkg::EXE_RES_ARITH;
        mem_load_o       = 1'b0;
        mem_store_o      = 1'b0;
        mem_size_o       = core_pkg::MEM_SIZE_B;
        kernel_o         = 1'b0;
        refetch_o        = 1'b0;

        case (opcode)
            core_pkg::EXE_SLTI:   aluop_o = core_pkg::EXE_SLT_OP;
            core_pkg::EXE_SLTUI:  aluop_o = core_pkg::EXE_SLTU_OP;
            core_pkg::EXE_ADDI_W: aluop_o = core_pkg::EXE_ADD_OP;
            core_pkg::EXE_ANDI, core_pkg::EXE_ORI, core_pkg::EXE_XORI: begin
                alusel_o = core_pkg::EXE_RES_LOGIC;
                imm_o    = imm_zext; // Logic ops zero-extend
                if (opcode == core_pkg::EXE_ANDI) aluop_o = core_pkg::EXE_AND_OP;
                else if (opcode == core_pkg::EXE_ORI) aluop_o = core_pkg::EXE_OR_OP;
                else aluop_o = core_pkg::EXE_XOR_OP;
            end
            core_pkg::EXE_LD_B, core_pkg::EXE_LD_BU: begin
                mem_load_o = 1'b1;
                aluop_o    = (opcode == core_pkg::EXE_LD_B) ? core_pkg::EXE_LD_B_OP
                                                             : core_pkg::EXE_LD_BU_OP;
            end
            core_pkg::EXE_LD_H, core_pkg::EXE_LD_HU: begin
                mem_load_o = 1'b1;
                mem_size_o = core_pkg::MEM_SIZE_H;
                aluop_o    = (opcode == core_pkg::EXE_LD_H) ? core_pkg::EXE_LD_H_OP
                                                             : core_pkg::EXE_LD_HU_OP;
            end
            core_pkg::EXE_LD_W: begin
                mem_load_o = 1'b1;
                mem_size_o = core_pkg::MEM_SIZE_W;
                aluop_o    = core_pkg::EXE_LD_W_OP;
            end
            core_pkg::EXE_ST_B: begin
                mem_store_o = 1'b1;
                aluop_o     = core_pkg::EXE_ST_B_OP;
            end
            core_pkg::EXE_ST_H: begin
                mem_store_o = 1'b1;
                mem_size_o  = core_pkg::MEM_SIZE_H;
                aluop_o     = core_pkg::EXE_ST_H_OP;
            end
            core_pkg::EXE_ST_W: begin
                mem_store_o = 1'b1;
                mem_size_o  = core_pkg::MEM_SIZE_W;
                aluop_o     = core_pkg::EXE_ST_W_OP;
            end
            core_pkg::EXE_CACOP: begin
                wb_en_o   = 1'b0;
                wb_addr_o = '0;
                aluop_o   = core_pkg::EXE_CACOP_OP;
                alusel_o  = core_pkg::EXE_RES_NOP;
                kernel_o  = 1'b1;
                refetch_o = 1'b1; // May invalidate the ICache
            end
            core_pkg::EXE_PRELD: begin
                // Hint only, treated as a NOP
                reg_read_valid_o = 2'b00;
                rj_addr_o        = '0;
                use_imm_o        = 1'b0;
                imm_o            = '0;
                wb_en_o          = 1'b0;
                wb_addr_o        = '0;
                alusel_o         = core_pkg::EXE_RES_NOP;
            end
            default: begin
                decode_valid_o   = 1'b0;
                reg_read_valid_o = 2'b00;
                rj_addr_o        = '0;
                use_imm_o        = 1'b0;
                imm_o            = '0;
                wb_en_o          = 1'b0;
                wb_addr_o        = '0;
                alusel_o         = core_pkg::EXE_RES_NOP;
            end
        endcase

        // Memory ops compute the address from the offset in execute
        if (mem_load_o || mem_store_o) begin
            use_imm_o = 1'b0;
            alusel_o  = core_pkg::EXE_RES_LOAD_STORE;
        end
        if (mem_store_o) begin
            reg_read_valid_o = 2'b11;
            rk_addr_o        = rd; // Store data comes from rd
            wb_en_o          = 1'b0;
            wb_addr_o        = '0;
        end
    end

endmodule

//--- design/decoder_1ri20.sv
`timescale 1ns/10ps

// Format {opcode[7], imm20, rd}
module decoder_1ri20 (
    input  core_pkg::instr_t    instr_i,
    output logic                decode_valid_o,
    output logic                use_pc_o,
    output core_pkg::data_t     imm_o,
    output core_pkg::reg_addr_t wb_addr_o,
    output core_pkg::aluop_t    aluop_o,
    output core_pkg::alusel_t   alusel_o
);

    logic [6:0]  opcode;
    logic [19:0] imm20;

    assign opcode = instr_i[31:25];
    assign imm20  = instr_i[24:5];

    always_comb begin
        decode_valid_o = 1'b1;
        use_pc_o       = 1'b0;
        imm_o          = {imm20, 12'b0}; // Upper immediate
        wb_addr_o      = instr_i[4:0];
        aluop_o        = core_pkg::EXE_NOP_OP;
        alusel_o       = core_pkg::EXE_RES_ARITH;

        case (opcode)
            core_pkg::EXE_LU12I_W: aluop_o = core_pkg::EXE_LUI_OP;
            core_pkg::EXE_PCADDU12I: begin
                aluop_o  = core_pkg::EXE_PCADDU_OP;
                use_pc_o = 1'b1; // pc is the first operand
            end
            default: begin
                decode_valid_o = 1'b0;
                imm_o          = '0;
                wb_addr_o      = '0;
                alusel_o       = core_pkg::EXE_RES_NOP;
            end
        endcase
    end

endmodule

//--- design/gpr_file.sv
`timescale 1ns/10ps

module gpr_file (
    input  logic                clk,
    input  logic                rst_n_i,
    input  core_pkg::reg_addr_t raddr1_i,
    input  core_pkg::reg_addr_t raddr2_i,
    output core_pkg::data_t     rdata1_o,
    output core_pkg::data_t     rdata2_o,
    input  logic                we_i,
    input  core_pkg::reg_addr_t waddr_i,
    input  core_pkg::data_t     wdata_i
);

    // No storage behind r0
    core_pkg::data_t regs [1:core_pkg::GPR_NUM-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < core_pkg::GPR_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Combinational reads, old value during a same-cycle write
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- design/id_stage.sv
`timescale 1ns/10ps

module id_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                instr_valid_i,
    output logic                instr_ready_o,
    input  core_pkg::instr_t    instr_i,
    input  core_pkg::data_t     pc_i,
    output core_pkg::reg_addr_t raddr1_o,
    output core_pkg::reg_addr_t raddr2_o,
    input  core_pkg::data_t     rdata1_i,
    input  core_pkg::data_t     rdata2_i,
    output logic                dec_valid_o,
    input  logic                dec_ready_i,
    output core_pkg::aluop_t    aluop_o,
    output core_pkg::alusel_t   alusel_o,
    output core_pkg::data_t     imm_o,
    output core_pkg::data_t     src1_o,
    output core_pkg::data_t     src2_o,
    output logic                use_imm_o,
    output logic                wb_en_o,
    output core_pkg::reg_addr_t wb_addr_o,
    output logic                mem_load_o,
    output logic                mem_store_o,
    output core_pkg::mem_size_t mem_size_o,
    output logic                kernel_o,
    output logic                refetch_o,
    output logic                illegal_o
);

    logic                d2_valid;
    logic [1:0]          d2_rd_valid;
    core_pkg::reg_addr_t d2_rk_addr;
    logic                d2_use_imm;
    core_pkg::data_t     d2_imm;
    logic                d2_wb_en;
    core_pkg::reg_addr_t d2_wb_addr;
    core_pkg::aluop_t    d2_aluop;
    core_pkg::alusel_t   d2_alusel;
    logic                d2_mem_load;
    logic                d2_mem_store;
    core_pkg::mem_size_t d2_mem_size;
    logic                d2_kernel;
    logic                d2_refetch;
    logic                d1_valid;
    logic                d1_use_pc;
    core_pkg::data_t     d1_imm;
    core_pkg::reg_addr_t d1_wb_addr;
    core_pkg::aluop_t    d1_aluop;
    core_pkg::alusel_t   d1_alusel;
    core_pkg::data_t     op1;
    core_pkg::data_t     op2;
    logic                accept;

    decoder_2ri12 decoder_2ri12_inst (
        .instr_i          (instr_i),
        .decode_valid_o   (d2_valid),
        .reg_read_valid_o (d2_rd_valid),
        .rj_addr_o        (raddr1_o),
        .rk_addr_o        (d2_rk_addr),
        .use_imm_o        (d2_use_imm),
        .imm_o            (d2_imm),
        .wb_en_o          (d2_wb_en),
        .wb_addr_o        (d2_wb_addr),
        .aluop_o          (d2_aluop),
        .alusel_o         (d2_alusel),
        .mem_load_o       (d2_mem_load),
        .mem_store_o      (d2_mem_store),
        .mem_size_o       (d2_mem_size),
        .kernel_o         (d2_kernel),
        .refetch_o        (d2_refetch)
    );

    decoder_1ri20 decoder_1ri20_inst (
        .instr_i        (instr_i),
        .decode_valid_o (d1_valid),
        .use_pc_o       (d1_use_pc),
        .imm_o          (d1_imm),
        .wb_addr_o      (d1_wb_addr),
        .aluop_o        (d1_aluop),
        .alusel_o       (d1_alusel)
    );

    assign raddr2_o = d2_rk_addr;

    // Unread ports contribute zero
    assign op1 = d2_rd_valid[0] ? rdata1_i : '0;
    assign op2 = d2_rd_valid[1] ? rdata2_i : '0;

    assign instr_ready_o = !dec_valid_o || dec_ready_i;
    assign accept        = instr_valid_i && instr_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
            aluop_o     <= core_pkg::EXE_NOP_OP;
            alusel_o    <= core_pkg::EXE_RES_NOP;
            imm_o       <= '0;
            src1_o      <= '0;
            src2_o      <= '0;
            use_imm_o   <= 1'b0;
            wb_en_o     <= 1'b0;
            wb_addr_o   <= '0;
            mem_load_o  <= 1'b0;
            mem_store_o <= 1'b0;
            mem_size_o  <= core_pkg::MEM_SIZE_B;
            kernel_o    <= 1'b0;
            refetch_o   <= 1'b0;
            illegal_o   <= 1'b0;
        end else if (accept) begin
            dec_valid_o <= 1'b1;
            // 2RI12 has priority, 1RI20 fills in the rest
            aluop_o     <= d2_valid ? d2_aluop : d1_aluop;
            alusel_o    <= d2_valid ? d2_alusel : d1_alusel;
            imm_o       <= d2_valid ? d2_imm : d1_imm;
            src1_o      <= d2_valid ? op1 : (d1_use_pc ? pc_i : '0);
            src2_o      <= d2_valid ? op2 : '0;
            use_imm_o   <= d2_valid ? d2_use_imm : d1_valid;
            wb_en_o     <= d2_valid ? d2_wb_en : d1_valid;
            wb_addr_o   <= d2_valid ? d2_wb_addr : d1_wb_addr;
            mem_load_o  <= d2_mem_load;
            mem_store_o <= d2_mem_store;
            mem_size_o  <= d2_mem_size;
            kernel_o    <= d2_kernel;
            refetch_o   <= d2_refetch;
            illegal_o   <= !d2_valid && !d1_valid; // Neither format claims it
        end else if (dec_ready_i) begin
            dec_valid_o <= 1'b0; // Packet taken, nothing new
        end
    end

endmodule

//--- design/id_top.sv
`timescale 1ns/10ps

module id_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                instr_valid_i,
    output logic                instr_ready_o,
    input  core_pkg::instr_t    instr_i,
    input  core_pkg::data_t     pc_i,
    output logic                dec_valid_o,
    input  logic                dec_ready_i,
    output core_pkg::aluop_t    aluop_o,
    output core_pkg::alusel_t   alusel_o,
    output core_pkg::data_t     imm_o,
    output core_pkg::data_t     src1_o,
    output core_pkg::data_t     src2_o,
    output logic                use_imm_o,
    output logic                wb_en_o,
    output core_pkg::reg_addr_t wb_addr_o,
    output logic                mem_load_o,
    output logic                mem_store_o,
    output core_pkg::mem_size_t mem_size_o,
    output logic                kernel_o,
    output logic                refetch_o,
    output logic                illegal_o,
    input  logic                wb_we_i,    // Writeback stand-in
    input  core_pkg::reg_addr_t wb_waddr_i,
    input  core_pkg::data_t     wb_wdata_i
);

    core_pkg::reg_addr_t raddr1;
    core_pkg::reg_addr_t raddr2;
    core_pkg::data_t     rdata1;
    core_pkg::data_t     rdata2;

    id_stage id_stage_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .raddr1_o      (raddr1),
        .raddr2_o      (raddr2),
        .rdata1_i      (rdata1),
        .rdata2_i      (rdata2),
        .dec_valid_o   (dec_valid_o),
        .dec_ready_i   (dec_ready_i),
        .aluop_o       (aluop_o),
        .alusel_o      (alusel_o),
        .imm_o         (imm_o),
        .src1_o        (src1_o),
        .src2_o        (src2_o),
        .use_imm_o     (use_imm_o),
        .wb_en_o       (wb_en_o),
        .wb_addr_o     (wb_addr_o),
        .mem_load_o    (mem_load_o),
        .mem_store_o   (mem_store_o),
        .mem_size_o    (mem_size_o),
        .kernel_o      (kernel_o),
        .refetch_o     (refetch_o),
        .illegal_o     (illegal_o)
    );

    gpr_file gpr_file_inst (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (wb_we_i),
        .waddr_i  (wb_waddr_i),
        .wdata_i  (wb_wdata_i)
    );

endmodule

//--- verif/id_assertions.sv
`timescale 1ns/10ps

module id_assertions (
    input logic         clk,
    input logic         rst_n_i,
    input logic         dec_valid_i,
    input logic         dec_ready_i,
    input logic [120:0] packet_i,   // Whole output packet
    input logic         illegal_i,
    input logic         wb_en_i,
    input logic         mem_load_i,
    input logic         mem_store_i
);

    reset_empty: assert property (@(posedge clk) !rst_n_i |-> !dec_valid_i)
        else $error("dec_valid_o high while reset is asserted");

    // Stalled packet must not move
    stall_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (dec_valid_i && !dec_ready_i) |=> (dec_valid_i && $stable(packet_i)))
        else $error("Output packet changed while stalled");

    illegal_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
        (dec_valid_i && illegal_i) |-> !(wb_en_i || mem_load_i || mem_store_i))
        else $error("Illegal packet carries an enable");

    load_xor_store: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mem_load_i && mem_store_i))
        else $error("Load and store flags both high");

endmodule

bind id_stage id_assertions id_assertions_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .dec_valid_i (dec_valid_o),
    .dec_ready_i (dec_ready_i),
    .packet_i    ({aluop_o, alusel_o, imm_o, src1_o, src2_o, use_imm_o, wb_en_o, wb_addr_o,
                   mem_load_o, mem_store_o, mem_size_o, kernel_o, refetch_o, illegal_o}),
    .illegal_i   (illegal_o),
    .wb_en_i     (wb_en_o),
    .mem_load_i  (mem_load_o),
    .mem_store_i (mem_store_o)
);

//--- verif/id_ref_model.svh
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// One expected output packet
typedef struct packed {
    core_pkg::aluop_t    aluop;
    core_pkg::alusel_t   alusel;
    core_pkg::data_t     imm;
    core_pkg::data_t     src1;
    core_pkg::data_t     src2;
    logic                use_imm;
    logic                wb_en;
    core_pkg::reg_addr_t wb_addr;
    logic                mem_load;
    logic                mem_store;
    core_pkg::mem_size_t mem_size;
    logic                kernel;
    logic                refetch;
    logic                illegal;
} packet_t;

// Shadow of the register file, entry 0 never written
core_pkg::data_t shadow_regs [0:core_pkg::GPR_NUM-1];

task automatic shadow_write(core_pkg::reg_addr_t addr, core_pkg::data_t value);
    if (addr != '0) begin
        shadow_regs[addr] = value;
    end
endtask

function automatic packet_t predict_packet(core_pkg::instr_t word, core_pkg::data_t pc);
    packet_t             p;
    logic [9:0]          op10;
    logic [6:0]          op7;
    core_pkg::reg_addr_t rd;
    core_pkg::data_t     sext12;
    logic                is_arith;
    logic                is_logic;
    logic                is_load;
    logic                is_store;
    logic                is_cacop;

    p        = '0;
    op10     = word[31:22];
    op7      = word[31:25];
    rd       = word[4:0];
    sext12   = {{20{word[21]}}, word[21:10]};
    is_arith = op10 inside {core_pkg::EXE_SLTI, core_pkg::EXE_SLTUI, core_pkg::EXE_ADDI_W};
    is_logic = op10 inside {core_pkg::EXE_ANDI, core_pkg::EXE_ORI, core_pkg::EXE_XORI};
    is_load  = op10 inside {core_pkg::EXE_LD_B, core_pkg::EXE_LD_H, core_pkg::EXE_LD_W,
                            core_pkg::EXE_LD_BU, core_pkg::EXE_LD_HU};
    is_store = op10 inside {core_pkg::EXE_ST_B, core_pkg::EXE_ST_H, core_pkg::EXE_ST_W};
    is_cacop = (op10 == core_pkg::EXE_CACOP);

    case (op10)
        core_pkg::EXE_SLTI:   p.aluop = core_pkg::EXE_SLT_OP;
        core_pkg::EXE_SLTUI:  p.aluop = core_pkg::EXE_SLTU_OP;
        core_pkg::EXE_ADDI_W: p.aluop = core_pkg::EXE_ADD_OP;
        core_pkg::EXE_ANDI:   p.aluop = core_pkg::EXE_AND_OP;
        core_pkg::EXE_ORI:    p.aluop = core_pkg::EXE_OR_OP;
        core_pkg::EXE_XORI:   p.aluop = core_pkg::EXE_XOR_OP;
        core_pkg::EXE_LD_B:   p.aluop = core_pkg::EXE_LD_B_OP;
        core_pkg::EXE_LD_H:   p.aluop = core_pkg::EXE_LD_H_OP;
        core_pkg::EXE_LD_W:   p.aluop = core_pkg::EXE_LD_W_OP;
        core_pkg::EXE_LD_BU:  p.aluop = core_pkg::EXE_LD_BU_OP;
        core_pkg::EXE_LD_HU:  p.aluop = core_pkg::EXE_LD_HU_OP;
        core_pkg::EXE_ST_B:   p.aluop = core_pkg::EXE_ST_B_OP;
        core_pkg::EXE_ST_H:   p.aluop = core_pkg::EXE_ST_H_OP;
        core_pkg::EXE_ST_W:   p.aluop = core_pkg::EXE_ST_W_OP;
        core_pkg::EXE_CACOP:  p.aluop = core_pkg::EXE_CACOP_OP;
        default:              p.aluop = core_pkg::EXE_NOP_OP;
    endcase

    if (is_arith || is_logic || is_load || is_store || is_cacop) begin
        p.src1      = shadow_regs[word[9:5]];
        p.imm       = is_logic ? {20'd0, word[21:10]} : sext12;
        p.use_imm   = is_arith || is_logic || is_cacop;
        p.wb_en     = is_arith || is_logic || is_load;
        p.wb_addr   = p.wb_en ? rd : '0;
        p.mem_load  = is_load;
        p.mem_store = is_store;
        p.kernel    = is_cacop;
        p.refetch   = is_cacop;
        p.alusel    = is_arith ? core_pkg::EXE_RES_ARITH :
                      is_logic ? core_pkg::EXE_RES_LOGIC :
                      is_cacop ? core_pkg::EXE_RES_NOP : core_pkg::EXE_RES_LOAD_STORE;
        if (is_store) begin
            p.src2 = shadow_regs[rd]; // Store data
        end
        if (op10 inside {core_pkg::EXE_LD_H, core_pkg::EXE_LD_HU, core_pkg::EXE_ST_H}) begin
            p.mem_size = core_pkg::MEM_SIZE_H;
        end else if (op10 inside {core_pkg::EXE_LD_W, core_pkg::EXE_ST_W}) begin
            p.mem_size = core_pkg::MEM_SIZE_W;
        end
    end else if (op7 == core_pkg::EXE_LU12I_W || op7 == core_pkg::EXE_PCADDU12I) begin
        p.alusel  = core_pkg::EXE_RES_ARITH;
        p.imm     = {word[24:5], 12'd0};
        p.use_imm = 1'b1;
        p.wb_en   = 1'b1;
        p.wb_addr = rd;
        if (op7 == core_pkg::EXE_PCADDU12I) begin
            p.aluop = core_pkg::EXE_PCADDU_OP;
            p.src1  = pc;
        end else begin
            p.aluop = core_pkg::EXE_LUI_OP;
        end
    end else if (op10 != core_pkg::EXE_PRELD) begin
        p.illegal = 1'b1; // PRELD keeps the empty packet
    end
    return p;
endfunction

`endif

//--- verif/tb_id_top.sv
`timescale 1ns/10ps

module tb_id_top;

    localparam int NUM_INSTR = 600;
    // Preload and up to 8 cycles per word under random valid/ready
    localparam int TIMEOUT_CYCLES = 8 * NUM_INSTR + 200;

    localparam logic [9:0] OPS_2RI12 [16] = '{
        core_pkg::EXE_SLTI,  core_pkg::EXE_SLTUI, core_pkg::EXE_ADDI_W, core_pkg::EXE_ANDI,
        core_pkg::EXE_ORI,   core_pkg::EXE_XORI,  core_pkg::EXE_LD_B,   core_pkg::EXE_LD_H,
        core_pkg::EXE_LD_W,  core_pkg::EXE_ST_B,  core_pkg::EXE_ST_H,   core_pkg::EXE_ST_W,
        core_pkg::EXE_LD_BU, core_pkg::EXE_LD_HU, core_pkg::EXE_PRELD,  core_pkg::EXE_CACOP
    };

    logic                clk = 1'b0;
    logic                rst_n_i;
    logic                instr_valid_i;
    logic                instr_ready_o;
    core_pkg::instr_t    instr_i;
    core_pkg::data_t     pc_i;
    logic                dec_valid_o;
    logic                dec_ready_i;
    core_pkg::aluop_t    aluop_o;
    core_pkg::alusel_t   alusel_o;
    core_pkg::data_t     imm_o;
    core_pkg::data_t     src1_o;
    core_pkg::data_t     src2_o;
    logic                use_imm_o;
    logic                wb_en_o;
    core_pkg::reg_addr_t wb_addr_o;
    logic                mem_load_o;
    logic                mem_store_o;
    core_pkg::mem_size_t mem_size_o;
    logic                kernel_o;
    logic                refetch_o;
    logic                illegal_o;
    logic                wb_we_i;
    core_pkg::reg_addr_t wb_waddr_i;
    core_pkg::data_t     wb_wdata_i;

    `include "id_ref_model.svh"

    packet_t expected_q [$];
    int      accepted = 0;
    int      checked = 0;
    int      presented = 0;
    int      cycle_count = 0;
    logic    accepted_last = 1'b0;

    id_top id_top_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .dec_valid_o   (dec_valid_o),
        .dec_ready_i   (dec_ready_i),
        .aluop_o       (aluop_o),
        .alusel_o      (alusel_o),
        .imm_o         (imm_o),
        .src1_o        (src1_o),
        .src2_o        (src2_o),
        .use_imm_o     (use_imm_o),
        .wb_en_o       (wb_en_o),
        .wb_addr_o     (wb_addr_o),
        .mem_load_o    (mem_load_o),
        .mem_store_o   (mem_store_o),
        .mem_size_o    (mem_size_o),
        .kernel_o      (kernel_o),
        .refetch_o     (refetch_o),
        .illegal_o     (illegal_o),
        .wb_we_i       (wb_we_i),
        .wb_waddr_i    (wb_waddr_i),
        .wb_wdata_i    (wb_wdata_i)
    );

    always #20 clk = ~clk;

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_data(string field, core_pkg::data_t act, core_pkg::data_t exp);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, field, act, exp));
        end
    endtask

    task automatic check_addr(string field, core_pkg::reg_addr_t act, core_pkg::reg_addr_t exp);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got %0d expected %0d", $time, field, act, exp));
        end
    endtask

    task automatic check_aluop(string field, core_pkg::aluop_t act, core_pkg::aluop_t exp);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, field, act, exp));
        end
    endtask

    task automatic check_alusel(string field, core_pkg::alusel_t act, core_pkg::alusel_t exp);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got %0d expected %0d", $time, field, act, exp));
        end
    endtask

    task automatic check_size(string field, core_pkg::mem_size_t act, core_pkg::mem_size_t exp);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got %0d expected %0d", $time, field, act, exp));
        end
    endtask

    task automatic check_flag(string field, logic act, logic exp);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, field, act, exp));
        end
    endtask

    task automatic compare_packet(packet_t exp);
        check_aluop("aluop_o", aluop_o, exp.aluop);
        check_alusel("alusel_o", alusel_o, exp.alusel);
        check_data("imm_o", imm_o, exp.imm);
        check_data("src1_o", src1_o, exp.src1);
        check_data("src2_o", src2_o, exp.src2);
        check_flag("use_imm_o", use_imm_o, exp.use_imm);
        check_flag("wb_en_o", wb_en_o, exp.wb_en);
        check_addr("wb_addr_o", wb_addr_o, exp.wb_addr);
        check_flag("mem_load_o", mem_load_o, exp.mem_load);
        check_flag("mem_store_o", mem_store_o, exp.mem_store);
        check_size("mem_size_o", mem_size_o, exp.mem_size);
        check_flag("kernel_o", kernel_o, exp.kernel);
        check_flag("refetch_o", refetch_o, exp.refetch);
        check_flag("illegal_o", illegal_o, exp.illegal);
    endtask

    function automatic core_pkg::instr_t random_instr();
        int               kind;
        core_pkg::instr_t w;

        kind = $urandom_range(0, 19);
        w    = $urandom();
        if (kind < 16) begin
            w[31:22] = OPS_2RI12[kind];
        end else if (kind == 16) begin
            w[31:25] = core_pkg::EXE_LU12I_W;
        end else if (kind == 17) begin
            w[31:25] = core_pkg::EXE_PCADDU12I;
        end else begin
            w[31:30] = 2'b11; // No format claims this range
        end
        return w;
    endfunction

    // Model and scoreboard on the same edge as the DUT
    always @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < core_pkg::GPR_NUM; i++) begin
                shadow_regs[i] = '0;
            end
            accepted_last = 1'b0;
        end else begin
            if (accepted_last) begin
                check_flag("dec_valid_o one cycle after accept", dec_valid_o, 1'b1);
            end
            // Output register is empty when nothing is waiting in the model
            check_flag("instr_ready_o", instr_ready_o,
                       (expected_q.size() == 0) || dec_ready_i);
            if (dec_valid_o && dec_ready_i) begin
                if (expected_q.size() == 0) begin
                    abort_run("Output packet appeared with no accepted instruction behind it");
                end
                compare_packet(expected_q.pop_front());
                checked++;
            end
            accepted_last = instr_valid_i && instr_ready_o;
            if (accepted_last) begin
                expected_q.push_back(predict_packet(instr_i, pc_i)); // Pre-write values
                accepted++;
            end
            if (wb_we_i) begin
                shadow_write(wb_waddr_i, wb_wdata_i);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles, only %0d of %0d packets checked",
                                TIMEOUT_CYCLES, checked, NUM_INSTR));
        end
    end

    initial begin
        void'($urandom(14));
        rst_n_i       <= 1'b0;
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
        pc_i          <= '0;
        dec_ready_i   <= 1'b0;
        wb_we_i       <= 1'b0;
        wb_waddr_i    <= '0;
        wb_wdata_i    <= '0;
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);
        check_flag("dec_valid_o after reset", dec_valid_o, 1'b0);
        compare_packet('0);

        // Fill every register once
        for (int r = 1; r < core_pkg::GPR_NUM; r++) begin
            wb_we_i    <= 1'b1;
            wb_waddr_i <= 5'(r);
            wb_wdata_i <= $urandom();
            @(posedge clk);
        end

        while (checked < NUM_INSTR) begin
            if (!instr_valid_i || instr_ready_o) begin
                if (presented < NUM_INSTR && $urandom_range(0, 9) < 7) begin
                    instr_i       <= random_instr();
                    pc_i          <= $urandom() & 32'hffff_fffc;
                    instr_valid_i <= 1'b1;
                    presented++;
                end else begin
                    instr_valid_i <= 1'b0;
                end
            end
            dec_ready_i <= ($urandom_range(0, 3) != 0);
            wb_we_i     <= 1'($urandom_range(0, 1));
            wb_waddr_i  <= 5'($urandom_range(0, 31));
            wb_wdata_i  <= $urandom();
            @(posedge clk);
        end

        @(posedge clk);
        if (expected_q.size() != 0 || accepted != NUM_INSTR) begin
            abort_run($sformatf("Run ended with %0d accepted and %0d packets never delivered",
                                accepted, expected_q.size()));
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

//--- flist.f
+incdir+verif
design/core_pkg.sv
design/decoder_2ri12.sv
design/decoder_1ri20.sv
design/gpr_file.sv
design/id_stage.sv
design/id_top.sv
verif/id_assertions.sv
verif/tb_id_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_id_top -f flist.f -o sim_id_top
./obj_dir/sim_id_top
